//--- verilog/div_pkg.sv
package div_pkg;

    // Default operand width for the divider
    parameter int div_width = 16;

    // Iteration counter, wide enough for operands up to 32 bits
    typedef logic [5:0] count_t;

    // Controller states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,   // Waiting for start
        st_load    = 2'd1,   // Operand capture
        st_iterate = 2'd2,   // Shift-subtract steps
        st_finish  = 2'd3    // Done cycle, results held
    } div_state_e;

endpackage

//--- verilog/div_ctrl_if.sv
`timescale 1ns/1ps

interface div_ctrl_if #(
    parameter int WIDTH = div_pkg::div_width
) ();

    import div_pkg::*;

    // Count value at which all WIDTH steps have been applied
    localparam count_t last_count = count_t'(WIDTH);

    // Strobes from the controller
    logic load;       // One-cycle operand capture
    logic step;       // High once per iteration cycle
    logic store;      // One-cycle result capture
    logic clear;      // Zero the working registers

    // Status from the datapath
    logic   count_done;
    count_t count;    // Also observed by the checker

    modport controller (
        output load,
        output step,
        output store,
        output clear,
        input  count_done
    );

    modport datapath (
        input  load,
        input  step,
        input  store,
        input  clear,
        output count_done,
        output count
    );

endinterface

//--- verilog/div_step_alu.sv
`timescale 1ns/1ps

// One restoring division step, purely combinational
module div_step_alu #(
    parameter int WIDTH = div_pkg::div_width
) (
    input  logic [WIDTH-1:0] acc,
    input  logic [WIDTH-1:0] quo,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] acc_next,
    output logic [WIDTH-1:0] quo_next
);

    logic [WIDTH:0]   partial;   // Shifted accumulator with the bit from the quotient
    logic [WIDTH+1:0] diff;      // Trial difference, top bit is the borrow
    logic             borrow;

    // Left shift of the {acc, quo} pair, keeping the bit that leaves acc
    assign partial = {acc, quo[WIDTH-1]};

    // Trial subtraction with one guard bit
    assign diff   = {1'b0, partial} - {2'b00, divisor};
    assign borrow = diff[WIDTH+1];

    // Restore on borrow, otherwise keep the difference.
    // The kept value is always below the divisor, so WIDTH bits suffice.
    always_comb begin
        if (borrow) begin
            acc_next = partial[WIDTH-1:0];
        end else begin
            acc_next = diff[WIDTH-1:0];
        end
    end

    // New quotient bit enters at the bottom
    assign quo_next = {quo[WIDTH-2:0], ~borrow};

endmodule

//--- verilog/div_datapath.sv
`timescale 1ns/1ps

module div_datapath #(
    parameter int WIDTH = div_pkg::div_width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    div_ctrl_if.datapath     ctrl,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    import div_pkg::*;

    // Working registers
    logic [WIDTH-1:0] divisor_q;
    logic [WIDTH-1:0] acc_q;      // Partial remainder
    logic [WIDTH-1:0] quo_q;      // Dividend shifting out, quotient shifting in
    count_t           count_q;

    // Step results
    logic [WIDTH-1:0] acc_next;
    logic [WIDTH-1:0] quo_next;

    div_step_alu #(
        .WIDTH(WIDTH)
    ) u_step_alu (
        .acc      (acc_q),
        .quo      (quo_q),
        .divisor  (divisor_q),
        .acc_next (acc_next),
        .quo_next (quo_next)
    );

    // Divisor holds for the whole operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divisor_q <= '0;
        end else if (ctrl.clear) begin
            divisor_q <= '0;
        end else if (ctrl.load) begin
            divisor_q <= divisor;
        end
    end

    // Accumulator and quotient pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            quo_q <= '0;
        end else if (ctrl.clear) begin
            acc_q <= '0;
            quo_q <= '0;
        end else if (ctrl.load) begin
            acc_q <= '0;
            quo_q <= dividend;   // Dividend bits leave from the top
        end else if (ctrl.step) begin
            acc_q <= acc_next;
            quo_q <= quo_next;
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (ctrl.clear || ctrl.load) begin
            count_q <= '0;
        end else if (ctrl.step) begin
            count_q <= count_q + count_t'(1);
        end
    end

    assign ctrl.count      = count_q;
    assign ctrl.count_done = (count_q == ctrl.last_count);   // All steps applied

    // Result registers, held until the next store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (ctrl.store) begin
            quotient  <= quo_q;
            remainder <= acc_q;
        end
    end

endmodule

//--- verilog/div_controller.sv
`timescale 1ns/1ps

module div_controller (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    div_ctrl_if.controller ctrl,
    output logic           busy,
    output logic           done
);

    import div_pkg::*;

    div_state_e state;
    div_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = st_iterate;
            end
            st_iterate: begin
                if (ctrl.count_done) begin
                    state_next = st_finish;
                end
            end
            st_finish: begin
                // A new start may already be taken in the done cycle
                if (start) begin
                    state_next = st_load;
                end else begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Strobes to the datapath, decoded from the state
    always_comb begin
        ctrl.load  = 1'b0;
        ctrl.step  = 1'b0;
        ctrl.store = 1'b0;
        ctrl.clear = 1'b0;
        case (state)
            st_load: begin
                ctrl.load = 1'b1;
            end
            st_iterate: begin
                ctrl.step  = !ctrl.count_done;
                // Last iterate cycle captures the result for the done cycle
                ctrl.store = ctrl.count_done;
            end
            st_finish: begin
                ctrl.clear = 1'b1;   // Working registers back to zero
            end
            default: begin
                ctrl.load = 1'b0;
            end
        endcase
    end

    // Status
    assign busy = (state == st_load) || (state == st_iterate);
    assign done = (state == st_finish);   // Exactly one cycle

endmodule

//--- verilog/div_top.sv
`timescale 1ns/1ps

module div_top #(
    parameter int WIDTH = div_pkg::div_width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,       // Ignored while busy
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             busy,
    output logic             done,        // One-cycle result strobe
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    // Strobes and status between controller and datapath
    div_ctrl_if #(
        .WIDTH(WIDTH)
    ) ctrl_if ();

    div_controller u_controller (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .ctrl  (ctrl_if.controller),
        .busy  (busy),
        .done  (done)
    );

    div_datapath #(
        .WIDTH(WIDTH)
    ) u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .dividend  (dividend),
        .divisor   (divisor),
        .ctrl      (ctrl_if.datapath),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

//--- tb/div_top_chk.sv
`timescale 1ns/1ps

// Bound to div_top to compare results against a reference division
module div_top_chk #(
    parameter int WIDTH = div_pkg::div_width
) (
    input logic                clk,
    input logic                rst_n,
    input logic                start,
    input logic [WIDTH-1:0]    dividend,
    input logic [WIDTH-1:0]    divisor,
    input logic                busy,
    input logic                done,
    input logic [WIDTH-1:0]    quotient,
    input logic [WIDTH-1:0]    remainder,
    input div_pkg::div_state_e state,
    input div_pkg::count_t     count
);

    import div_pkg::*;

    logic [WIDTH-1:0] cap_dividend;
    logic [WIDTH-1:0] cap_divisor;
    logic [WIDTH-1:0] exp_quotient;
    logic [WIDTH-1:0] exp_remainder;
    logic             started;     // Set by the first accepted start
    int               fail_count = 0;

    // Operands of the accepted start in the idle or done cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_dividend <= '0;
            cap_divisor  <= '0;
            started      <= 1'b0;
        end else if (start && !busy) begin
            cap_dividend <= dividend;
            cap_divisor  <= divisor;
            started      <= 1'b1;
        end
    end

    // Reference result with all ones and the dividend for a zero divisor
    always_comb begin
        if (cap_divisor == '0) begin
            exp_quotient  = '1;
            exp_remainder = cap_dividend;
        end else begin
            exp_quotient  = cap_dividend / cap_divisor;
            exp_remainder = cap_dividend % cap_divisor;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !busy && !done && quotient == '0 && remainder == '0)
        else begin
            $error("busy, done or a result was nonzero before the first start");
            fail_count++;
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> quotient == exp_quotient && remainder == exp_remainder)
        else begin
            $error("result in the done cycle differs from the reference division");
            fail_count++;
        end

    // Load plus WIDTH+1 iterate cycles before the done cycle
    a_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> (busy && !done) [*(WIDTH+2)] ##1 (done && !busy))
        else begin
            $error("busy or done did not follow the expected timing after start");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done was high for more than one cycle");
            fail_count++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> $stable(quotient) && $stable(remainder))
        else begin
            $error("quotient or remainder changed outside the done cycle");
            fail_count++;
        end

    a_last_step: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_iterate && count == count_t'(WIDTH)) |=> state == st_finish)
        else begin
            $error("controller did not finish after the last iteration");
            fail_count++;
        end

endmodule

bind div_top div_top_chk #(
    .WIDTH(WIDTH)
) u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .dividend  (dividend),
    .divisor   (divisor),
    .busy      (busy),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder),
    .state     (u_controller.state),
    .count     (ctrl_if.count)
);

//--- tb/tb_div_top.sv
`timescale 1ns/1ps

module tb_div_top;

    localparam int WIDTH        = 16;
    localparam int CLK_PERIOD   = 100;
    localparam int DONE_TIMEOUT = 4 * WIDTH + 20;
    localparam int HOLD_CYCLES  = 8;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [WIDTH-1:0] dividend;
    logic [WIDTH-1:0] divisor;
    logic             busy;
    logic             done;
    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] remainder;

    logic [31:0] lfsr_state;
    int          tests_run;
    int          tests_failed;
    int          errors;
    int          errors_at_test_start;

    div_top #(
        .WIDTH(WIDTH)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [WIDTH-1:0] random_word(input int nbits);
        logic [WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            w = {w[WIDTH-2:0], lfsr_bit()};   // One step per bit
        end
        return w;
    endfunction

    task automatic begin_test();
        errors_at_test_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_test_start) begin
            $display("test %-18s ok", name);
        end else begin
            tests_failed++;
            $display("test %-18s FAILED, %0d errors", name, errors - errors_at_test_start);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the start edge
    task automatic start_div(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        dividend = a;
        divisor  = b;
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
    endtask

    task automatic wait_done(input string name, output int lat);
        lat = 0;
        while (!done && lat < DONE_TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (!done) begin
            $display("timeout in test %s, no done after %0d cycles", name, lat);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic check_result(input string name, input logic [WIDTH-1:0] a,
                                input logic [WIDTH-1:0] b, input int lat);
        logic [WIDTH-1:0] exp_q;
        logic [WIDTH-1:0] exp_r;
        if (b == '0) begin
            exp_q = '1;
            exp_r = a;
        end else begin
            exp_q = a / b;
            exp_r = a % b;
        end
        assert (quotient == exp_q) else begin
            $display("mismatch %s quotient: expected %h, actual %h", name, exp_q, quotient);
            errors++;
        end
        assert (remainder == exp_r) else begin
            $display("mismatch %s remainder: expected %h, actual %h", name, exp_r, remainder);
            errors++;
        end
        assert (lat == WIDTH + 2) else begin
            $display("mismatch %s latency: expected %0d, actual %0d", name, WIDTH + 2, lat);
            errors++;
        end
        assert (!busy) else begin
            $display("busy still high in the done cycle of test %s", name);
            errors++;
        end
    endtask

    // Ends in the done cycle, so a following call starts back to back
    task automatic divide(input string name, input logic [WIDTH-1:0] a,
                          input logic [WIDTH-1:0] b);
        int lat;
        start_div(a, b);
        wait_done(name, lat);
        check_result(name, a, b, lat);
    endtask

    task automatic check_hold(input string name, input int cycles);
        logic [WIDTH-1:0] held_q;
        logic [WIDTH-1:0] held_r;
        held_q = quotient;
        held_r = remainder;
        repeat (cycles) begin
            @(negedge clk);
            assert (quotient == held_q && remainder == held_r) else begin
                $display("mismatch %s hold: expected %h/%h, actual %h/%h",
                         name, held_q, held_r, quotient, remainder);
                errors++;
            end
        end
    endtask

    initial begin
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        int               lat;
        int               extra_done;
        int               chk_errors;
        rst_n      = 1'b0;
        start      = 1'b0;
        dividend   = '0;
        divisor    = '0;
        lfsr_state = 32'h8241;
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        repeat (4) begin
            @(negedge clk);
            assert (!busy && !done && quotient == '0 && remainder == '0) else begin
                $display("mismatch reset_state: expected 0/0/0000/0000, actual %b/%b/%h/%h",
                         busy, done, quotient, remainder);
                errors++;
            end
        end
        end_test("reset_state");

        begin_test();
        divide("fixed_basic", 16'd1000, 16'd7);
        check_hold("fixed_basic", HOLD_CYCLES);
        divide("fixed_pow2", 16'h8000, 16'h0010);
        check_hold("fixed_pow2", HOLD_CYCLES);
        end_test("fixed");

        begin_test();
        for (int i = 0; i < 24; i++) begin
            a = random_word(WIDTH);
            b = random_word((i % 2 == 0) ? WIDTH : 6);   // Small divisors too
            if (b == '0) begin
                b = 1;
            end
            divide("random", a, b);
        end
        end_test("random");

        begin_test();
        divide("div_by_zero", 16'h1234, 16'h0000);
        divide("zero_by_zero", 16'h0000, 16'h0000);
        divide("small_dividend", 16'd5, 16'd9);
        divide("equal", 16'h3c3c, 16'h3c3c);
        divide("max_max", 16'hffff, 16'hffff);
        divide("max_by_one", 16'hffff, 16'h0001);
        divide("max_by_msb", 16'hffff, 16'h8000);
        end_test("edge_cases");

        // Second start lands in iterate and must be dropped
        begin_test();
        check_hold("idle_gap", 3);
        start_div(16'd50000, 16'd123);
        repeat (3) @(negedge clk);
        start_div(16'd7, 16'd3);
        wait_done("start_during_busy", lat);
        check_result("start_during_busy", 16'd50000, 16'd123, lat + 4);
        extra_done = 0;
        repeat (WIDTH + 4) begin
            @(negedge clk);
            if (done) begin
                extra_done++;
            end
        end
        assert (extra_done == 0) else begin
            $display("mismatch start_during_busy extra done: expected 0, actual %0d",
                     extra_done);
            errors++;
        end
        end_test("start_during_busy");

        begin_test();
        divide("back_to_back_1", 16'd40000, 16'd300);
        divide("back_to_back_2", 16'd12345, 16'd0);
        divide("back_to_back_3", 16'd77, 16'd77);
        end_test("back_to_back");

        begin_test();
        check_hold("hold_after_chain", HOLD_CYCLES);
        divide("hold", 16'hbeef, 16'h0101);
        check_hold("hold", 2 * HOLD_CYCLES);
        end_test("hold");

        repeat (3) @(negedge clk);
        chk_errors = UUT.u_chk.fail_count;
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, chk_errors);
        if (tests_failed == 0 && errors == 0 && chk_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/div_pkg.sv
verilog/div_ctrl_if.sv
verilog/div_step_alu.sv
verilog/div_datapath.sv
verilog/div_controller.sv
verilog/div_top.sv
tb/div_top_chk.sv
tb/tb_div_top.sv

//--- Bender.yml
package:
  name: div_top

sources:
  # RTL in compile order
  - files:
      - verilog/div_pkg.sv
      - verilog/div_ctrl_if.sv
      - verilog/div_step_alu.sv
      - verilog/div_datapath.sv
      - verilog/div_controller.sv
      - verilog/div_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - tb/div_top_chk.sv
      - tb/tb_div_top.sv
